/* logic/fir_decim_pkg.sv */
package fir_decim_pkg;

    // --------------------
    // Sizes
    localparam int SAMPLE_W  = 18;
    localparam int NTAPS     = 32;
    localparam int TAP_W     = 5;
    localparam int DECIM     = 8;
    localparam int ACC_W     = 48;
    localparam int COEF_FRAC = 17;
    localparam int PC_W      = 5;

    // First word of the wait/push loop
    localparam logic [PC_W-1:0] LOOP_PC = 5'd2;

    // --------------------
    // Microcode
    typedef enum logic [2:0] {
        OP_CLEAR,
        OP_WAIT_IN,
        OP_PUSH,
        OP_MAC_START,
        OP_MAC,
        OP_DRAIN,
        OP_MOVE_RES,
        OP_JUMP
    } seq_op_t;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_WAIT,
        ST_REPEAT
    } seq_state_t;

    // --------------------
    // Low-pass taps, cutoff near fs/16, unity DC gain in Q17
    localparam logic signed [SAMPLE_W-1:0] COEFS [NTAPS] = '{
        -42,
        -143,
        -300,
        -536,
        -802,
        -981,
        -925,
        -449,
        609,
        2329,
        4668,
        7447,
        10360,
        13032,
        15078,
        16191,
        16191,
        15078,
        13032,
        10360,
        7447,
        4668,
        2329,
        609,
        -449,
        -925,
        -981,
        -802,
        -536,
        -300,
        -143,
        -42
    };

endpackage

/* logic/microcode_sequencer.sv */
`timescale 1ns/1ps

module microcode_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic sample_in_rdy,
    output logic clear_wr,
    output logic push_x,
    output logic mac_start,
    output logic mac_en,
    output logic move_res
);
    import fir_decim_pkg::*;

    logic [PC_W-1:0]  pc;
    logic [PC_W-1:0]  pc_next;
    logic [TAP_W-1:0] rep_cnt;
    seq_state_t       state;
    seq_op_t          op;
    seq_op_t          op_next;
    logic             advance;
    logic             jump;
    logic             arm;

    // --------------------
    // Microprogram
    function automatic seq_op_t rom_word(input logic [PC_W-1:0] addr);
        seq_op_t word;
        case (addr)
            5'd0:    word = OP_CLEAR;
            5'd1:    word = OP_JUMP;
            5'd2:    word = OP_WAIT_IN;
            5'd3:    word = OP_PUSH;
            5'd4:    word = OP_WAIT_IN;
            5'd5:    word = OP_PUSH;
            5'd6:    word = OP_WAIT_IN;
            5'd7:    word = OP_PUSH;
            5'd8:    word = OP_WAIT_IN;
            5'd9:    word = OP_PUSH;
            5'd10:   word = OP_WAIT_IN;
            5'd11:   word = OP_PUSH;
            5'd12:   word = OP_WAIT_IN;
            5'd13:   word = OP_PUSH;
            5'd14:   word = OP_WAIT_IN;
            5'd15:   word = OP_PUSH;
            5'd16:   word = OP_WAIT_IN;
            5'd17:   word = OP_PUSH;
            5'd18:   word = OP_MAC_START;
            5'd19:   word = OP_MAC;
            5'd20:   word = OP_DRAIN;
            5'd21:   word = OP_DRAIN;
            5'd22:   word = OP_MOVE_RES;
            default: word = OP_JUMP;
        endcase
        return word;
    endfunction

    assign op      = rom_word(pc);
    assign op_next = rom_word(pc_next);

    // Next PC
    always_comb begin
        advance = 1'b0;
        jump    = 1'b0;
        arm     = 1'b0;
        case (state)
            ST_RUN: begin
                case (op)
                    OP_WAIT_IN:       advance = sample_in_rdy;
                    OP_CLEAR, OP_MAC: arm = 1'b1;
                    OP_JUMP:          jump = 1'b1;
                    default:          advance = 1'b1;
                endcase
            end
            ST_WAIT: advance = sample_in_rdy;
            default: advance = (rep_cnt == '0);
        endcase
        if (jump)
            pc_next = LOOP_PC;
        else if (advance)
            pc_next = pc + 1'b1;
        else
            pc_next = pc;
    end

    // Entering a repeated word goes straight to ST_REPEAT
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            state   <= ST_RUN;
            rep_cnt <= '0;
        end else begin
            pc <= pc_next;
            if (arm) begin
                state   <= ST_REPEAT;
                rep_cnt <= TAP_W'(NTAPS - 1);
            end else if (advance || jump) begin
                state   <= (op_next == OP_CLEAR || op_next == OP_MAC) ? ST_REPEAT : ST_RUN;
                rep_cnt <= TAP_W'(NTAPS - 1);
            end else if (state == ST_REPEAT) begin
                rep_cnt <= rep_cnt - 1'b1;
            end else if (op == OP_WAIT_IN) begin
                state <= ST_WAIT;
            end
        end
    end

    // Strobes
    assign clear_wr  = (state == ST_REPEAT) && (op == OP_CLEAR);
    assign mac_en    = (state == ST_REPEAT) && (op == OP_MAC);
    assign push_x    = (op == OP_PUSH);
    assign mac_start = (op == OP_MAC_START);
    assign move_res  = (op == OP_MOVE_RES);

    // --------------------
    // Checks
    assert property (@(posedge clk) disable iff (reset)
        (state == ST_REPEAT) |-> (op == OP_CLEAR || op == OP_MAC))
        else $error("repeat state reached outside a repeated word");

    assert property (@(posedge clk) disable iff (reset)
        (state == ST_REPEAT && op == OP_MAC) |-> !sample_in_rdy)
        else $error("input sample arrived during the MAC burst");

endmodule

/* logic/delay_line.sv */
`timescale 1ns/1ps

module delay_line (
    input  logic clk,
    input  logic reset,
    input  logic sample_in_rdy,
    input  logic clear_wr,
    input  logic push_x,
    input  logic mac_start,
    input  logic mac_en,
    input  logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_in_l,
    input  logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_in_r,
    output logic signed [fir_decim_pkg::SAMPLE_W-1:0] xj_l,
    output logic signed [fir_decim_pkg::SAMPLE_W-1:0] xj_r,
    output logic xj_valid
);
    import fir_decim_pkg::*;

    logic signed [SAMPLE_W-1:0] cap_l;
    logic signed [SAMPLE_W-1:0] cap_r;
    logic [2*SAMPLE_W-1:0]      ram [NTAPS];
    logic [TAP_W-1:0]           head;
    logic [TAP_W-1:0]           wr_addr;
    logic [TAP_W-1:0]           rd_ptr;

    always_ff @(posedge clk) begin
        if (sample_in_rdy) begin
            cap_l <= sample_in_l;
            cap_r <= sample_in_r;
        end
    end

    // Head moves down and always points at the newest pair
    assign wr_addr = (head == '0) ? TAP_W'(NTAPS - 1) : head - 1'b1;

    always_ff @(posedge clk) begin
        if (clear_wr || push_x)
            ram[wr_addr] <= clear_wr ? '0 : {cap_l, cap_r};
        if (mac_en)
            {xj_l, xj_r} <= ram[rd_ptr];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head     <= '0;
            rd_ptr   <= '0;
            xj_valid <= 1'b0;
        end else begin
            xj_valid <= mac_en;
            if (clear_wr || push_x)
                head <= wr_addr;
            // Walk from newest towards oldest
            if (mac_start)
                rd_ptr <= head;
            else if (mac_en)
                rd_ptr <= (rd_ptr == TAP_W'(NTAPS - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset) mac_en |-> !(clear_wr || push_x))
        else $error("delay line written during the MAC read burst");

endmodule

/* logic/tap_mac.sv */
`timescale 1ns/1ps

module tap_mac (
    input  logic clk,
    input  logic reset,
    input  logic mac_start,
    input  logic xj_valid,
    input  logic signed [fir_decim_pkg::SAMPLE_W-1:0] xj_l,
    input  logic signed [fir_decim_pkg::SAMPLE_W-1:0] xj_r,
    output logic signed [fir_decim_pkg::ACC_W-1:0]    acc_l,
    output logic signed [fir_decim_pkg::ACC_W-1:0]    acc_r
);
    import fir_decim_pkg::*;

    logic [TAP_W-1:0]             coef_idx;
    logic signed [SAMPLE_W-1:0]   coef;
    logic signed [2*SAMPLE_W-1:0] prod_l;
    logic signed [2*SAMPLE_W-1:0] prod_r;
    logic                         prod_valid;

    // Coefficient ROM
    assign coef = COEFS[coef_idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coef_idx   <= '0;
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= xj_valid;
            if (mac_start)
                coef_idx <= '0;
            else if (xj_valid)
                coef_idx <= (coef_idx == TAP_W'(NTAPS - 1)) ? '0 : coef_idx + 1'b1;
        end
    end

    // --------------------
    // Multiply stage
    always_ff @(posedge clk) begin
        if (xj_valid) begin
            prod_l <= xj_l * coef;
            prod_r <= xj_r * coef;
        end
    end

    // --------------------
    // Accumulate stage, one tap behind the multiplier
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_l <= '0;
            acc_r <= '0;
        end else if (mac_start) begin
            acc_l <= '0;
            acc_r <= '0;
        end else if (prod_valid) begin
            acc_l <= acc_l + ACC_W'(prod_l);
            acc_r <= acc_r + ACC_W'(prod_r);
        end
    end

endmodule

/* logic/output_stage.sv */
`timescale 1ns/1ps

module output_stage (
    input  logic clk,
    input  logic reset,
    input  logic move_res,
    input  logic signed [fir_decim_pkg::ACC_W-1:0]    acc_l,
    input  logic signed [fir_decim_pkg::ACC_W-1:0]    acc_r,
    output logic sample_out_rdy,
    output logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_l,
    output logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_r
);
    import fir_decim_pkg::*;

    // Drop the coefficient fraction, clamp to 18 bits
    function automatic logic signed [SAMPLE_W-1:0] scale_sat(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] shifted;
        logic signed [ACC_W-1:0] hi_lim;
        logic signed [ACC_W-1:0] lo_lim;
        shifted = acc >>> COEF_FRAC;
        hi_lim  = (ACC_W'(1) <<< (SAMPLE_W - 1)) - 1;
        lo_lim  = -hi_lim - 1;
        if (shifted > hi_lim)
            return {1'b0, {(SAMPLE_W - 1){1'b1}}};
        else if (shifted < lo_lim)
            return {1'b1, {(SAMPLE_W - 1){1'b0}}};
        else
            return shifted[SAMPLE_W-1:0];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out_rdy <= 1'b0;
            sample_out_l   <= '0;
            sample_out_r   <= '0;
        end else begin
            sample_out_rdy <= move_res;
            if (move_res) begin
                sample_out_l <= scale_sat(acc_l);
                sample_out_r <= scale_sat(acc_r);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) sample_out_rdy |=> !sample_out_rdy)
        else $error("output strobe wider than one cycle");

endmodule

/* logic/fir_decim_top.sv */
`timescale 1ns/1ps

module fir_decim_top (
    input  logic clk,
    input  logic reset,
    input  logic sample_in_rdy,
    input  logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_in_l,
    input  logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_in_r,
    output logic sample_out_rdy,
    output logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_l,
    output logic signed [fir_decim_pkg::SAMPLE_W-1:0] sample_out_r
);
    import fir_decim_pkg::*;

    logic                       clear_wr;
    logic                       push_x;
    logic                       mac_start;
    logic                       mac_en;
    logic                       move_res;
    logic signed [SAMPLE_W-1:0] xj_l;
    logic signed [SAMPLE_W-1:0] xj_r;
    logic                       xj_valid;
    logic signed [ACC_W-1:0]    acc_l;
    logic signed [ACC_W-1:0]    acc_r;

    // --------------------
    // Decode
    microcode_sequencer microcode_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .sample_in_rdy (sample_in_rdy),
        .clear_wr      (clear_wr),
        .push_x        (push_x),
        .mac_start     (mac_start),
        .mac_en        (mac_en),
        .move_res      (move_res)
    );

    // --------------------
    // Execute
    delay_line delay_line_inst (
        .clk           (clk),
        .reset         (reset),
        .sample_in_rdy (sample_in_rdy),
        .clear_wr      (clear_wr),
        .push_x        (push_x),
        .mac_start     (mac_start),
        .mac_en        (mac_en),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .xj_l          (xj_l),
        .xj_r          (xj_r),
        .xj_valid      (xj_valid)
    );

    tap_mac tap_mac_inst (
        .clk       (clk),
        .reset     (reset),
        .mac_start (mac_start),
        .xj_valid  (xj_valid),
        .xj_l      (xj_l),
        .xj_r      (xj_r),
        .acc_l     (acc_l),
        .acc_r     (acc_r)
    );

    // --------------------
    // Result
    output_stage output_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .move_res       (move_res),
        .acc_l          (acc_l),
        .acc_r          (acc_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out_l   (sample_out_l),
        .sample_out_r   (sample_out_r)
    );

endmodule

/* testbench/tb_fir_decim.sv */
`timescale 1ns/1ps

module tb_fir_decim;
    import fir_decim_pkg::*;

    localparam int MAX_HIST     = 512;
    localparam int MAX_OUTS     = 64;
    localparam int IN_GAP       = 48;
    localparam int CLEAR_WAIT   = 64;
    localparam int OUT_TIMEOUT  = 64;
    localparam int DONE_TIMEOUT = 500;
    localparam int RANDOM_OUTS  = 40;
    localparam int COUNT_OUTS   = 5;

    localparam logic signed [SAMPLE_W-1:0] FULL_POS = 18'sh1FFFF;
    localparam logic signed [SAMPLE_W-1:0] FULL_NEG = 18'sh20000;
    localparam logic signed [SAMPLE_W-1:0] DC_L     = 18'sd50000;
    localparam logic signed [SAMPLE_W-1:0] DC_R     = -18'sd70000;

    logic                       clk;
    logic                       reset;
    logic                       sample_in_rdy;
    logic signed [SAMPLE_W-1:0] sample_in_l;
    logic signed [SAMPLE_W-1:0] sample_in_r;
    logic                       sample_out_rdy;
    logic signed [SAMPLE_W-1:0] sample_out_l;
    logic signed [SAMPLE_W-1:0] sample_out_r;

    logic signed [SAMPLE_W-1:0] hist_l [MAX_HIST];
    logic signed [SAMPLE_W-1:0] hist_r [MAX_HIST];
    logic signed [SAMPLE_W-1:0] out_l  [MAX_OUTS];
    logic signed [SAMPLE_W-1:0] out_r  [MAX_OUTS];
    int                         n_in;
    int                         n_groups;
    int                         n_checked;
    int                         n_pulses;
    int                         n_mismatch;
    int                         n_other;
    int                         seed;
    string                      test_name;

    fir_decim_top fir_decim_top_inst (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in_l    (sample_in_l),
        .sample_in_r    (sample_in_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out_l   (sample_out_l),
        .sample_out_r   (sample_out_r)
    );

    always #2 clk = ~clk;

    // --------------------
    // Reference model
    function automatic logic signed [SAMPLE_W-1:0] clamp_sample(input longint value);
        longint hi;
        longint lo;
        hi = longint'(FULL_POS);
        lo = longint'(FULL_NEG);
        if (value > hi)
            return FULL_POS;
        if (value < lo)
            return FULL_NEG;
        return value[SAMPLE_W-1:0];
    endfunction

    // Newest sample at idx and older ones below it
    function automatic logic signed [SAMPLE_W-1:0] fir_ref(
        input logic signed [SAMPLE_W-1:0] hist [MAX_HIST],
        input int idx
    );
        longint sum;
        int     j;
        sum = 0;
        for (int k = 0; k < NTAPS; k++) begin
            j = idx - k;
            if (j >= 0)
                sum += longint'(COEFS[k]) * longint'(hist[j]);
        end
        return clamp_sample(sum >>> COEF_FRAC);
    endfunction

    task automatic check_sample(input string name,
                                input logic signed [SAMPLE_W-1:0] expected,
                                input logic signed [SAMPLE_W-1:0] actual);
        if (actual !== expected) begin
            n_mismatch++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            n_mismatch++;
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // --------------------
    // Stimulus helpers
    task automatic send_sample(input logic signed [SAMPLE_W-1:0] l,
                               input logic signed [SAMPLE_W-1:0] r);
        @(posedge clk);
        sample_in_rdy <= 1'b1;
        sample_in_l   <= l;
        sample_in_r   <= r;
        hist_l[n_in] = l;
        hist_r[n_in] = r;
        n_in++;
        if (n_in % DECIM == 0)
            n_groups++;
        @(posedge clk);
        sample_in_rdy <= 1'b0;
        repeat (IN_GAP - 2) @(posedge clk);
    endtask

    task automatic send_random(input int count);
        logic signed [SAMPLE_W-1:0] l;
        logic signed [SAMPLE_W-1:0] r;
        for (int i = 0; i < count; i++) begin
            l = SAMPLE_W'($random(seed));
            r = SAMPLE_W'($random(seed));
            send_sample(l, r);
        end
    endtask

    task automatic restart();
        @(posedge clk);
        reset         <= 1'b1;
        sample_in_rdy <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < MAX_HIST; i++) begin
            hist_l[i] = '0;
            hist_r[i] = '0;
        end
        n_in      = 0;
        n_groups  = 0;
        n_checked = 0;
        n_pulses  = 0;
        // Clear phase of the sequencer
        repeat (CLEAR_WAIT) @(posedge clk);
    endtask

    task automatic wait_outputs_done();
        int waited;
        waited = 0;
        while (n_checked < n_groups && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (n_checked < n_groups) begin
            n_other++;
            $display("Test %s timed out with %0d outputs still missing",
                     test_name, n_groups - n_checked);
        end
    endtask

    // --------------------
    // Output checker
    initial begin : compare_outputs
        int                         waited;
        int                         idx;
        logic                       prev_rdy;
        seq_op_t                    cur_op;
        logic signed [SAMPLE_W-1:0] exp_l;
        logic signed [SAMPLE_W-1:0] exp_r;
        waited   = 0;
        prev_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                waited   = 0;
                prev_rdy = 1'b0;
            end else if (sample_out_rdy) begin
                if (prev_rdy) begin
                    n_other++;
                    $display("Output strobe in test %s stayed high for two cycles", test_name);
                end else if (n_checked >= n_groups) begin
                    n_pulses++;
                    n_other++;
                    $display("Output in test %s came before its eighth input", test_name);
                end else begin
                    n_pulses++;
                    idx   = DECIM * n_checked + DECIM - 1;
                    exp_l = fir_ref(hist_l, idx);
                    exp_r = fir_ref(hist_r, idx);
                    check_sample($sformatf("%s out %0d left", test_name, n_checked),
                                 exp_l, sample_out_l);
                    check_sample($sformatf("%s out %0d right", test_name, n_checked),
                                 exp_r, sample_out_r);
                    out_l[n_checked] = sample_out_l;
                    out_r[n_checked] = sample_out_r;
                    n_checked++;
                end
                waited = 0;
            end else if (n_checked < n_groups) begin
                waited++;
                if (waited > OUT_TIMEOUT) begin
                    cur_op = fir_decim_top_inst.microcode_sequencer_inst.op;
                    n_other++;
                    $display("No output %0d in test %s, sequencer stuck at %s",
                             n_checked, test_name, cur_op.name());
                    n_checked++;
                    waited = 0;
                end
            end
            prev_rdy = sample_out_rdy;
        end
    end

    // --------------------
    // Test sequence
    initial begin : run_tests
        longint                     scaled;
        longint                     coef_sum;
        logic signed [SAMPLE_W-1:0] expected;
        clk           = 1'b0;
        reset         = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        seed          = 96;
        n_mismatch    = 0;
        n_other       = 0;
        test_name     = "impulse";
        restart();

        // Left impulse walks through the decimated taps
        send_sample(FULL_POS, '0);
        for (int i = 1; i < NTAPS; i++)
            send_sample('0, '0);
        wait_outputs_done();
        for (int m = 0; m < NTAPS / DECIM; m++) begin
            scaled   = (longint'(COEFS[DECIM * m + DECIM - 1]) * longint'(FULL_POS)) >>> COEF_FRAC;
            expected = scaled[SAMPLE_W-1:0];
            check_sample($sformatf("impulse tap %0d left", m), expected, out_l[m]);
            check_sample($sformatf("impulse tap %0d right", m), '0, out_r[m]);
        end

        test_name = "dc";
        restart();
        coef_sum = 0;
        for (int k = 0; k < NTAPS; k++)
            coef_sum += longint'(COEFS[k]);
        for (int i = 0; i < 6 * DECIM; i++)
            send_sample(DC_L, DC_R);
        wait_outputs_done();
        for (int m = NTAPS / DECIM - 1; m < 6; m++) begin
            check_sample($sformatf("dc settled %0d left", m),
                         clamp_sample((coef_sum * longint'(DC_L)) >>> COEF_FRAC), out_l[m]);
            check_sample($sformatf("dc settled %0d right", m),
                         clamp_sample((coef_sum * longint'(DC_R)) >>> COEF_FRAC), out_r[m]);
        end

        test_name = "random";
        restart();
        send_random(RANDOM_OUTS * DECIM);
        wait_outputs_done();
        check_count("random outputs", RANDOM_OUTS, n_pulses);

        // Signs follow the taps so the full window overflows
        test_name = "saturation";
        restart();
        for (int i = 0; i < NTAPS; i++) begin
            if (COEFS[NTAPS - 1 - i] >= 0)
                send_sample(FULL_POS, FULL_NEG);
            else
                send_sample(FULL_NEG, FULL_POS);
        end
        wait_outputs_done();
        check_sample("saturation left", FULL_POS, out_l[NTAPS / DECIM - 1]);
        check_sample("saturation right", FULL_NEG, out_r[NTAPS / DECIM - 1]);

        test_name = "count";
        restart();
        send_random(DECIM - 1);
        repeat (IN_GAP) @(posedge clk);
        check_count("count outputs before eighth input", 0, n_pulses);
        send_random(COUNT_OUTS * DECIM - (DECIM - 1));
        wait_outputs_done();
        check_count("count output pulses", COUNT_OUTS, n_pulses);

        test_name = "reset";
        restart();
        send_random(3 * DECIM + 4);
        wait_outputs_done();
        restart();
        send_random(3 * DECIM);
        wait_outputs_done();
        check_count("outputs after reset", 3, n_pulses);

        $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* filelist.f */
logic/fir_decim_pkg.sv
logic/microcode_sequencer.sv
logic/delay_line.sv
logic/tap_mac.sv
logic/output_stage.sv
logic/fir_decim_top.sv
testbench/tb_fir_decim.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fir_decim
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
